// ==== rtl/des_pkg.sv ====
`default_nettype none

package des_pkg;

   // --------------------
   // table sizes and address map

   localparam int GATE_COUNT = 256;
   localparam int EDGE_COUNT = 1024;
   localparam int GATE_AW    = $clog2(GATE_COUNT);
   localparam int EDGE_AW    = $clog2(EDGE_COUNT);

   localparam logic [11:0] REG_CTRL_ADDR = 12'h000;

   // paddr[13:12] picks the region, the same code is used as the table select
   localparam logic [1:0] REGION_REG  = 2'd0;
   localparam logic [1:0] REGION_GATE = 2'd1;
   localparam logic [1:0] REGION_SPAN = 2'd2;
   localparam logic [1:0] REGION_EDGE = 2'd3;

   // --------------------
   // logic values, gates and tasks

   typedef enum logic [1:0] {LOGIC_0, LOGIC_1, LOGIC_X, LOGIC_Z} logic_val_t;

   typedef enum logic [2:0] {BUF, INV, NAND2, NOR2, AND2, OR2, XOR2, XNOR2} gate_t;

   typedef struct packed {
      logic [31:0] ts;      // time in [31:8], sequence field in [7:0]
      logic [11:0] locale;  // gate id
      logic        ttype;   // 0 is an input change, 1 is an output change
      logic [2:0]  args;    // input port in bit 2, logic value below it
   } task_t;

   typedef struct packed {
      logic [5:0]  seq;
      logic_val_t  out;
      logic_val_t  in0;
      logic_val_t  in1;
      logic        unused;
      gate_t       gate;
      logic [15:0] delay;
   } gate_rec_t;

   typedef struct packed {
      logic [15:0] span_end;
      logic [15:0] span_begin;
   } fanout_span_t;

   typedef struct packed {
      logic [17:0] unused_hi;
      logic [11:0] neighbor;
      logic        unused_lo;
      logic        port;
   } edge_t;

   // one APB word, seen through the view of the table it is written to
   typedef union packed {
      gate_rec_t    rec;
      fanout_span_t span;
      edge_t        fan_edge;
   } mem_word_u;

   typedef struct packed {
      logic        valid;
      logic [1:0]  sel;
      logic [9:0]  index;
      mem_word_u   word;
   } mem_wr_t;

endpackage

`default_nettype wire

// ==== rtl/des_logic_eval.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_logic_eval import des_pkg::*; (
   input  logic_val_t p0,
   input  logic_val_t p1,
   input  gate_t      gate,
   output logic_val_t o
);

   logic any0, any1, both0, both1, known;

   assign any0  = (p0 == LOGIC_0) || (p1 == LOGIC_0);
   assign any1  = (p0 == LOGIC_1) || (p1 == LOGIC_1);
   assign both0 = (p0 == LOGIC_0) && (p1 == LOGIC_0);
   assign both1 = (p0 == LOGIC_1) && (p1 == LOGIC_1);
   assign known = (p0 inside {LOGIC_0, LOGIC_1}) && (p1 inside {LOGIC_0, LOGIC_1});

   always_comb begin
      o = LOGIC_X;
      case (gate)
         BUF: o = p0;
         INV: begin
            if (p0 == LOGIC_0) o = LOGIC_1;
            else if (p0 == LOGIC_1) o = LOGIC_0;
            else o = p0;  // X and Z pass through
         end
         // a controlling value wins over X or Z on the other input
         NAND2: if (any0) o = LOGIC_1; else if (both1) o = LOGIC_0;
         AND2:  if (any0) o = LOGIC_0; else if (both1) o = LOGIC_1;
         NOR2:  if (any1) o = LOGIC_0; else if (both0) o = LOGIC_1;
         OR2:   if (any1) o = LOGIC_1; else if (both0) o = LOGIC_0;
         XOR2: begin
            if (known) o = (p0 == p1) ? LOGIC_0 : LOGIC_1;
         end
         XNOR2: begin
            if (known) o = (p0 == p1) ? LOGIC_1 : LOGIC_0;
         end
         default: o = LOGIC_X;
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/des_gate_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_gate_unit import des_pkg::*; (
   input  logic               clk,
   input  logic               rstn,
   input  logic               task_valid,
   output logic               task_ready,
   input  task_t              in_task,
   output logic               res_valid,
   input  logic               res_ready,
   output task_t              res_task,
   input  logic               use_seq_number,
   input  mem_wr_t            cfg_wr,
   output logic               cfg_wr_busy,
   input  logic               cfg_rd_valid,
   input  logic [GATE_AW-1:0] cfg_rd_index,
   output logic [31:0]        cfg_rd_data
);

   typedef enum logic [1:0] {S_IDLE, S_READ, S_EVAL, S_RESULT} state_t;

   state_t     state;
   task_t      task_q;
   gate_rec_t  rec_q;
   gate_rec_t  new_rec;
   gate_rec_t  gate_mem [GATE_COUNT];

   logic_val_t in_val, new_in0, new_in1, new_out;
   logic [5:0] seq_inc;
   logic [31:0] new_ts;

   assign task_ready  = (state == S_IDLE);
   assign cfg_wr_busy = (state == S_READ) || (state == S_EVAL);  // record read-modify-write in flight

   // --------------------
   // evaluate

   assign in_val  = logic_val_t'(task_q.args[1:0]);
   assign new_in0 = task_q.args[2] ? rec_q.in0 : in_val;
   assign new_in1 = task_q.args[2] ? in_val : rec_q.in1;

   des_logic_eval u_eval (
      .p0   (new_in0),
      .p1   (new_in1),
      .gate (rec_q.gate),
      .o    (new_out)
   );

   assign seq_inc = rec_q.seq + 6'd1;

   always_comb begin
      new_rec     = rec_q;
      new_rec.in0 = new_in0;
      new_rec.in1 = new_in1;
      new_rec.out = new_out;
      new_rec.seq = 6'd0;
      new_ts      = task_q.ts + 32'(rec_q.delay);
      if (use_seq_number) begin
         new_rec.seq = seq_inc;
         // a zero delay gate must not move its output behind the input event
         if (seq_inc < task_q.ts[5:0] && rec_q.delay == 16'd0) begin
            new_rec.seq = task_q.ts[5:0];
         end
         new_ts = {task_q.ts[31:8] + 24'(rec_q.delay), 2'b00, new_rec.seq};
      end
   end

   // --------------------
   // control

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= S_IDLE;
         res_valid <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (task_valid) state <= S_READ;
            S_READ: state <= S_EVAL;
            S_EVAL: begin
               if (new_out != rec_q.out) begin
                  state     <= S_RESULT;
                  res_valid <= 1'b1;
               end else begin
                  state <= S_IDLE;  // the output did not change so there is nothing to spread
               end
            end
            S_RESULT: begin
               if (res_ready) begin
                  state     <= S_IDLE;
                  res_valid <= 1'b0;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (task_valid && task_ready) task_q <= in_task;
      if (state == S_READ) rec_q <= gate_mem[task_q.locale[GATE_AW-1:0]];
      if (state == S_EVAL) begin
         res_task.ts     <= new_ts;
         res_task.locale <= task_q.locale;
         res_task.ttype  <= 1'b1;
         res_task.args   <= {1'b0, new_out};
      end
   end

   // write-back has priority on the port and config writes wait on cfg_wr_busy
   always_ff @(posedge clk) begin
      if (state == S_EVAL) begin
         gate_mem[task_q.locale[GATE_AW-1:0]] <= new_rec;
      end else if (cfg_wr.valid && cfg_wr.sel == REGION_GATE) begin
         gate_mem[cfg_wr.index[GATE_AW-1:0]] <= cfg_wr.word.rec;
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_rd_valid) cfg_rd_data <= gate_mem[cfg_rd_index];
   end

   // a table write that meets the write-back would be lost on the shared port
   a_no_cfg_write_when_busy : assert property (@(posedge clk) disable iff (!rstn)
      (cfg_wr.valid && cfg_wr.sel == REGION_GATE) |-> !cfg_wr_busy);

   a_no_accept_with_result : assert property (@(posedge clk) disable iff (!rstn)
      res_valid |-> !task_ready);

endmodule

`default_nettype wire

// ==== rtl/des_fanout_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_fanout_unit import des_pkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    task_valid,
   output logic    task_ready,
   input  task_t   in_task,
   output logic    res_valid,
   input  logic    res_ready,
   output task_t   res_task,
   input  mem_wr_t cfg_wr
);

   typedef enum logic [1:0] {S_IDLE, S_SPAN, S_WALK} state_t;

   state_t       state;
   task_t        task_q;
   fanout_span_t span_q;
   logic [15:0]  ptr;  // next edge to load
   logic [EDGE_AW-1:0] rd_addr;
   logic         span_empty;
   logic         last_child;
   logic         load_child;

   fanout_span_t span_mem [GATE_COUNT];
   edge_t        edge_mem [EDGE_COUNT];

   assign task_ready = (state == S_IDLE);
   assign span_empty = (span_q.span_begin == span_q.span_end);
   assign last_child = (ptr == span_q.span_end);

   // first edge comes straight from the span, the rest from the walk pointer
   assign rd_addr    = (state == S_SPAN) ? span_q.span_begin[EDGE_AW-1:0] : ptr[EDGE_AW-1:0];
   assign load_child = (state == S_SPAN && !span_empty) ||
                       (state == S_WALK && res_ready && !last_child);

   // --------------------
   // control

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= S_IDLE;
         res_valid <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (task_valid) state <= S_SPAN;
            S_SPAN: begin
               if (span_empty) begin
                  state <= S_IDLE;  // no fanout, retire quietly
               end else begin
                  state     <= S_WALK;
                  res_valid <= 1'b1;
               end
            end
            S_WALK: begin
               if (res_ready && last_child) begin
                  state     <= S_IDLE;
                  res_valid <= 1'b0;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // --------------------
   // datapath

   always_ff @(posedge clk) begin
      if (task_valid && task_ready) begin
         task_q <= in_task;
         span_q <= span_mem[in_task.locale[GATE_AW-1:0]];
      end
      if (state == S_SPAN) ptr <= span_q.span_begin + 16'd1;
      else if (load_child) ptr <= ptr + 16'd1;
      if (load_child) begin
         res_task.ts     <= task_q.ts;
         res_task.locale <= edge_mem[rd_addr].neighbor;
         res_task.ttype  <= 1'b0;
         res_task.args   <= {edge_mem[rd_addr].port, task_q.args[1:0]};
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_wr.valid && cfg_wr.sel == REGION_SPAN) begin
         span_mem[cfg_wr.index[GATE_AW-1:0]] <= cfg_wr.word.span;
      end
      if (cfg_wr.valid && cfg_wr.sel == REGION_EDGE) begin
         edge_mem[cfg_wr.index[EDGE_AW-1:0]] <= cfg_wr.word.fan_edge;
      end
   end

   a_span_order : assert property (@(posedge clk) disable iff (!rstn)
      (state == S_SPAN) |-> (span_q.span_begin <= span_q.span_end));

endmodule

`default_nettype wire

// ==== rtl/des_task_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_task_switch import des_pkg::*; (
   input  logic  in_valid,
   output logic  in_ready,
   input  task_t in_task,
   output logic  gate_valid,
   input  logic  gate_ready,
   output task_t gate_task,
   output logic  fan_valid,
   input  logic  fan_ready,
   output task_t fan_task,
   input  logic  gate_res_valid,
   output logic  gate_res_ready,
   input  task_t gate_res_task,
   input  logic  fan_res_valid,
   output logic  fan_res_ready,
   input  task_t fan_res_task,
   output logic  out_valid,
   input  logic  out_ready,
   output task_t out_task,
   input  logic  clk,
   input  logic  rstn
);

   logic ptr;  // 0 favours the gate unit, 1 the fanout unit
   logic sel;

   // --------------------
   // dispatch by ttype
   assign gate_valid = in_valid && !in_task.ttype;
   assign fan_valid  = in_valid && in_task.ttype;
   assign gate_task  = in_task;
   assign fan_task   = in_task;
   assign in_ready   = in_task.ttype ? fan_ready : gate_ready;

   // --------------------
   // merge, the favoured source wins when it has something
   assign sel = (ptr ? fan_res_valid : gate_res_valid) ? ptr : !ptr;

   assign out_valid      = gate_res_valid || fan_res_valid;
   assign out_task       = sel ? fan_res_task : gate_res_task;
   assign gate_res_ready = out_ready && !sel;
   assign fan_res_ready  = out_ready && sel;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ptr <= 1'b0;
      end else if (out_valid) begin
         ptr <= out_ready ? !sel : sel;  // stay locked until the winner transfers
      end
   end

   a_out_hold : assert property (@(posedge clk) disable iff (!rstn)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_task)));

endmodule

`default_nettype wire

// ==== rtl/des_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_cfg_regs import des_pkg::*; (
   input  logic               clk,
   input  logic               rstn,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [13:0]        paddr,
   input  logic [31:0]        pwdata,
   output logic               pready,
   output logic [31:0]        prdata,
   output logic               use_seq_number,
   output mem_wr_t            cfg_wr,
   input  logic               cfg_wr_busy,
   output logic               cfg_rd_valid,
   output logic [GATE_AW-1:0] cfg_rd_index,
   input  logic [31:0]        cfg_rd_data
);

   logic [1:0] region;
   logic [9:0] index;
   logic       access;
   logic       wr_blocked;
   logic       ctrl_hit;
   logic       rd_pending;  // gate record read issued, data arrives this cycle

   assign region     = paddr[13:12];
   assign index      = paddr[11:2];
   assign access     = psel && penable;
   assign ctrl_hit   = (region == REGION_REG) && (paddr[11:0] == REG_CTRL_ADDR);
   assign wr_blocked = (region == REGION_GATE) && cfg_wr_busy;

   // --------------------
   // table write path

   always_comb begin
      cfg_wr.valid = access && pwrite && (region != REGION_REG) && !wr_blocked;
      cfg_wr.sel   = region;
      cfg_wr.index = index;
      cfg_wr.word  = pwdata;
   end

   // --------------------
   // read path

   assign cfg_rd_valid = access && !pwrite && (region == REGION_GATE) && !rd_pending;
   assign cfg_rd_index = index[GATE_AW-1:0];

   always_comb begin
      if (pwrite) pready = !wr_blocked;
      else if (region == REGION_GATE) pready = rd_pending;
      else pready = 1'b1;
   end

   always_comb begin
      prdata = 32'd0;
      if (ctrl_hit) prdata = {31'd0, use_seq_number};
      else if (region == REGION_GATE) prdata = cfg_rd_data;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_pending     <= 1'b0;
         use_seq_number <= 1'b1;
      end else begin
         if (cfg_rd_valid) rd_pending <= 1'b1;
         else if (access && pready) rd_pending <= 1'b0;
         if (access && pwrite && ctrl_hit) use_seq_number <= pwdata[0];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/des_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_tile import des_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        in_valid,
   output logic        in_ready,
   input  task_t       in_task,
   output logic        out_valid,
   input  logic        out_ready,
   output task_t       out_task,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [13:0] paddr,
   input  logic [31:0] pwdata,
   output logic        pready,
   output logic [31:0] prdata
);

   logic  gate_valid, gate_ready, fan_valid, fan_ready;
   task_t gate_task, fan_task;
   logic  gate_res_valid, gate_res_ready, fan_res_valid, fan_res_ready;
   task_t gate_res_task, fan_res_task;

   logic               use_seq_number;
   mem_wr_t            cfg_wr;
   logic               cfg_wr_busy;
   logic               cfg_rd_valid;
   logic [GATE_AW-1:0] cfg_rd_index;
   logic [31:0]        cfg_rd_data;

   des_task_switch u_switch (
      .in_valid, .in_ready, .in_task,
      .gate_valid, .gate_ready, .gate_task,
      .fan_valid, .fan_ready, .fan_task,
      .gate_res_valid, .gate_res_ready, .gate_res_task,
      .fan_res_valid, .fan_res_ready, .fan_res_task,
      .out_valid, .out_ready, .out_task,
      .clk, .rstn
   );

   des_gate_unit u_gate (
      .clk, .rstn,
      .task_valid (gate_valid), .task_ready (gate_ready), .in_task (gate_task),
      .res_valid (gate_res_valid), .res_ready (gate_res_ready), .res_task (gate_res_task),
      .use_seq_number, .cfg_wr, .cfg_wr_busy,
      .cfg_rd_valid, .cfg_rd_index, .cfg_rd_data
   );

   des_fanout_unit u_fanout (
      .clk, .rstn,
      .task_valid (fan_valid), .task_ready (fan_ready), .in_task (fan_task),
      .res_valid (fan_res_valid), .res_ready (fan_res_ready), .res_task (fan_res_task),
      .cfg_wr
   );

   des_cfg_regs u_cfg (
      .clk, .rstn,
      .psel, .penable, .pwrite, .paddr, .pwdata, .pready, .prdata,
      .use_seq_number, .cfg_wr, .cfg_wr_busy,
      .cfg_rd_valid, .cfg_rd_index, .cfg_rd_data
   );

endmodule

`default_nettype wire

// ==== verification/des_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_clk_gen (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      rstn = 1'b0;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;  // released right after the second rising edge
   end

endmodule

`default_nettype wire

// ==== verification/des_tile_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_tile_tb import des_pkg::*; ();

   localparam int NG        = 64;  // gates that get tables and traffic
   localparam int WAIT_MAX  = 200;
   localparam int DRAIN_MAX = 4000;

   logic        clk, rstn;
   logic        in_valid, in_ready, out_valid, out_ready;
   task_t       in_task, out_task;
   logic        psel, penable, pwrite, pready;
   logic [13:0] paddr;
   logic [31:0] pwdata, prdata;

   gate_rec_t    model_rec  [NG];
   fanout_span_t model_span [NG];
   edge_t        model_edge [EDGE_COUNT];
   task_t        exp_res_q [$];    // ttype 1 results of the gate unit
   task_t        exp_child_q [$];  // ttype 0 children of the fanout unit

   logic [31:0] rnd_state;
   logic        seq_on, stress_on;
   int          errors, checks;

   des_clk_gen u_clk (.clk, .rstn);

   des_tile dut (
      .clk, .rstn,
      .in_valid, .in_ready, .in_task,
      .out_valid, .out_ready, .out_task,
      .psel, .penable, .pwrite, .paddr, .pwdata, .pready, .prdata
   );

   // --------------------
   // random numbers and reference model

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] rand_word();
      rnd_state = lcg_next(rnd_state);
      return {rnd_state[15:0], rnd_state[31:16]};  // the weak low bits end up on top
   endfunction

   function automatic logic_val_t flip(input logic_val_t v);
      if (v == LOGIC_0) return LOGIC_1;
      if (v == LOGIC_1) return LOGIC_0;
      return v;
   endfunction

   function automatic logic_val_t eval_gate(input gate_t g, input logic_val_t a,
                                            input logic_val_t b);
      logic_val_t and_v, or_v, xor_v;
      and_v = LOGIC_X;
      or_v  = LOGIC_X;
      xor_v = LOGIC_X;
      if (a == LOGIC_0 || b == LOGIC_0) and_v = LOGIC_0;
      else if (a == LOGIC_1 && b == LOGIC_1) and_v = LOGIC_1;
      if (a == LOGIC_1 || b == LOGIC_1) or_v = LOGIC_1;
      else if (a == LOGIC_0 && b == LOGIC_0) or_v = LOGIC_0;
      if ((a inside {LOGIC_0, LOGIC_1}) && (b inside {LOGIC_0, LOGIC_1}))
         xor_v = (a == b) ? LOGIC_0 : LOGIC_1;
      case (g)
         BUF:     return a;
         INV:     return flip(a);
         AND2:    return and_v;
         NAND2:   return flip(and_v);
         OR2:     return or_v;
         NOR2:    return flip(or_v);
         XOR2:    return xor_v;
         default: return flip(xor_v);
      endcase
   endfunction

   function automatic logic [31:0] expected_ts(input task_t t, input gate_rec_t r,
                                               input logic use_seq, output logic [5:0] seq);
      logic [23:0] tm;
      if (!use_seq) begin
         seq = 6'd0;
         return t.ts + {16'd0, r.delay};
      end
      seq = r.seq + 6'd1;
      if (r.delay == 16'd0 && seq < t.ts[5:0]) seq = t.ts[5:0];  // zero delay clamps up
      tm = t.ts[31:8] + {8'd0, r.delay};
      return {tm, 2'b00, seq};
   endfunction

   task automatic predict_gate(input task_t t);
      gate_rec_t  r, nr;
      task_t      e;
      logic_val_t v;
      logic [5:0] s;
      r  = model_rec[t.locale[5:0]];
      v  = logic_val_t'(t.args[1:0]);
      nr = r;
      if (t.args[2]) nr.in1 = v;
      else nr.in0 = v;
      nr.out   = eval_gate(r.gate, nr.in0, nr.in1);
      e.ts     = expected_ts(t, r, seq_on, s);
      nr.seq   = s;
      e.locale = t.locale;
      e.ttype  = 1'b1;
      e.args   = {1'b0, nr.out};
      if (nr.out != r.out) exp_res_q.push_back(e);
      model_rec[t.locale[5:0]] = nr;
   endtask

   task automatic expand_fanout(input task_t t);
      fanout_span_t sp;
      edge_t        ed;
      task_t        c;
      int           i;
      sp = model_span[t.locale[5:0]];
      for (i = int'(sp.span_begin); i < int'(sp.span_end); i++) begin
         ed       = model_edge[i[9:0]];
         c.ts     = t.ts;
         c.locale = ed.neighbor;
         c.ttype  = 1'b0;
         c.args   = {ed.port, t.args[1:0]};
         exp_child_q.push_back(c);
      end
   endtask

   // --------------------
   // reporting

   task automatic report_mismatch(input string name, input logic [47:0] got,
                                  input logic [47:0] exp);
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
   endtask

   task automatic abort_run(input string why);
      $display("timeout: %s", why);
      $display("checks %0d errors %0d", checks, errors);
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   // --------------------
   // each driver starts and ends 1 ns after a rising edge

   task automatic apb_xfer(input logic wr, input logic [1:0] region, input logic [9:0] index,
                           input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = {region, index, 2'b00};
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      n = 0;
      @(negedge clk);
      while (!pready) begin
         if (n == WAIT_MAX) abort_run("pready stayed low");
         n++;
         @(negedge clk);
      end
      rdata = prdata;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_word(input logic [1:0] region, input logic [9:0] index,
                             input logic [31:0] data);
      logic [31:0] unused_rd;
      apb_xfer(1'b1, region, index, data, unused_rd);
   endtask

   task automatic read_check(input logic [1:0] region, input logic [9:0] index,
                             input logic [31:0] exp, input string name);
      logic [31:0] rd;
      apb_xfer(1'b0, region, index, 32'd0, rd);
      checks++;
      if (rd !== exp) report_mismatch(name, {16'd0, rd}, {16'd0, exp});
   endtask

   task automatic send_task(input task_t t);
      int n;
      in_valid = 1'b1;
      in_task  = t;
      n = 0;
      @(negedge clk);
      while (!in_ready) begin
         if (n == WAIT_MAX) abort_run("in_ready stayed low");
         n++;
         @(negedge clk);
      end
      if (t.ttype) expand_fanout(t);  // the transfer happens on the coming edge
      else predict_gate(t);
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   function automatic task_t random_task(input logic ttype);
      task_t       t;
      logic [31:0] w;
      w        = rand_word();
      t.ts     = rand_word();
      t.locale = 12'(w[23:8] % NG);
      t.ttype  = ttype;
      t.args   = w[2:0];
      return t;
   endfunction

   task automatic drain();
      int n;
      n = 0;
      while (exp_res_q.size() != 0 || exp_child_q.size() != 0) begin
         if (n == DRAIN_MAX) abort_run("expected output tasks never arrived");
         n++;
         @(posedge clk);
         #1;
      end
      repeat (4) begin  // lets a silent gate item finish its write-back
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_records();
      int g;
      for (g = 0; g < NG; g++) read_check(REGION_GATE, 10'(g), model_rec[g[5:0]], "gate record");
   endtask

   // --------------------
   // output side

   initial begin : ready_drive
      logic [31:0] rdy_state;
      rdy_state = lcg_next(32'd32);
      out_ready = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         rdy_state = lcg_next(rdy_state);
         if (stress_on) out_ready = (rdy_state[30:29] != 2'b00);
         else out_ready = 1'b1;
      end
   end

   initial begin : monitor
      task_t e;
      forever begin
         @(negedge clk);
         if (rstn && out_valid && out_ready) begin
            if (out_task.ttype ? exp_res_q.size() == 0 : exp_child_q.size() == 0) begin
               errors++;
               $display("unexpected output task at %0t: %h", $time, out_task);
            end else begin
               if (out_task.ttype) e = exp_res_q.pop_front();
               else e = exp_child_q.pop_front();
               checks++;
               if (out_task !== e) report_mismatch("out_task", out_task, e);
            end
         end
      end
   end

   // --------------------
   // stimulus

   initial begin : stimulus
      task_t        t;
      gate_rec_t    rec;
      fanout_span_t sp;
      edge_t        ed;
      logic [31:0]  w;
      int           g, i, k, n, next_edge;
      in_valid  = 1'b0;
      in_task   = '0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      errors    = 0;
      checks    = 0;
      seq_on    = 1'b1;
      stress_on = 1'b0;
      rnd_state = 32'd32;
      n = 0;
      @(negedge clk);
      while (!rstn) begin
         if (n == WAIT_MAX) abort_run("reset never released");
         n++;
         @(negedge clk);
      end
      @(posedge clk);
      #1;

      checks++;
      if (in_ready !== 1'b1) report_mismatch("in_ready", {47'd0, in_ready}, 48'd1);
      checks++;
      if (out_valid !== 1'b0) report_mismatch("out_valid", {47'd0, out_valid}, 48'd0);

      read_check(REGION_REG, 10'd0, 32'd1, "ctrl");
      write_word(REGION_REG, 10'd0, 32'd0);
      read_check(REGION_REG, 10'd0, 32'd0, "ctrl");
      write_word(REGION_REG, 10'd0, 32'd1);
      read_check(REGION_REG, 10'd0, 32'd1, "ctrl");

      next_edge = 0;
      for (g = 0; g < NG; g++) begin
         rec = gate_rec_t'(rand_word());
         if (rec.delay[15:14] == 2'b00) rec.delay = 16'd0;  // some zero delay gates
         model_rec[g[5:0]] = rec;
         write_word(REGION_GATE, 10'(g), rec);
         read_check(REGION_GATE, 10'(g), rec, "gate record");
         sp.span_begin = 16'(next_edge);
         next_edge += int'(rand_word() % 32'd4);
         sp.span_end = 16'(next_edge);
         model_span[g[5:0]] = sp;
         write_word(REGION_SPAN, 10'(g), sp);
      end
      for (i = 0; i < next_edge; i++) begin
         ed = edge_t'(rand_word());
         ed.neighbor = 12'(rand_word() % NG);
         model_edge[i[9:0]] = ed;
         write_word(REGION_EDGE, 10'(i), ed);
      end

      // loaded span and edge words are not readable
      read_check(REGION_SPAN, 10'(NG - 1), 32'd0, "span region read");
      read_check(REGION_EDGE, 10'd0, 32'd0, "edge region read");

      for (k = 0; k < 200; k++) send_task(random_task(1'b0));
      drain();
      check_records();

      write_word(REGION_REG, 10'd0, 32'd0);
      seq_on = 1'b0;
      for (k = 0; k < 150; k++) send_task(random_task(1'b0));
      drain();
      check_records();

      // each span once including the empty ones
      for (g = 0; g < NG; g++) begin
         t = random_task(1'b1);
         t.locale = 12'(g);
         send_task(t);
      end
      drain();

      write_word(REGION_REG, 10'd0, 32'd1);
      seq_on    = 1'b1;
      stress_on = 1'b1;
      for (k = 0; k < 300; k++) begin
         w = rand_word();
         send_task(random_task(w[4]));
      end
      drain();
      stress_on = 1'b0;
      check_records();

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== des_tile.f ====
rtl/des_pkg.sv
rtl/des_logic_eval.sv
rtl/des_gate_unit.sv
rtl/des_fanout_unit.sv
rtl/des_task_switch.sv
rtl/des_cfg_regs.sv
rtl/des_tile.sv
verification/des_clk_gen.sv
verification/des_tile_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= des_tile_tb
FILELIST  ?= des_tile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
